/* bench/soc_testdata.txt */
// kind port op addr wdata strb exp_data exp_resp chk
// kind 0 preload, 1 alone, 2 with next line, f end; chk 0 exact, 1 resp only, 2 rising
0 0 0 00000000 11223344 f 00000000 0 0
0 0 0 00000004 55667788 f 00000000 0 0
0 0 0 00000010 a0b0c0d0 f 00000000 0 0
0 0 0 00000020 01020304 f 00000000 0 0
0 0 0 00000024 cafef00d f 00000000 0 0
0 0 0 00000034 00000000 f 00000000 0 0
// both ports in the same cycle, port 0 first after reset
2 0 0 00000000 00000000 0 11223344 0 0
1 1 0 00000004 00000000 0 55667788 0 0
// partial write then read back
1 1 1 00000010 deadbeef 5 00000000 0 0
1 1 0 00000010 00000000 0 a0adc0ef 0 0
1 0 0 00000020 00000000 0 01020304 0 0
// mtime low twice, then high
1 1 0 0200bff8 00000000 0 00000000 0 1
1 1 0 0200bff8 00000000 0 00000000 0 2
1 0 0 0200bffc 00000000 0 00000000 0 0
// timer write and unmapped offset
1 1 1 0200bff8 12345678 f 00000000 2 0
1 0 0 02000010 00000000 0 00000000 3 0
2 0 1 00000030 89abcdef f 00000000 0 0
1 1 0 00000024 00000000 0 cafef00d 0 0
1 0 0 00000030 00000000 0 89abcdef 0 0
2 1 1 00000034 00005a00 2 00000000 0 0
1 0 0 00000004 00000000 0 55667788 0 0
1 1 0 00000034 00000000 0 00005a00 0 0
2 0 0 0200bffc 00000000 0 00000000 0 1
1 1 0 00000010 00000000 0 a0adc0ef 0 0
f 0 0 00000000 00000000 0 00000000 0 0

/* bench/soc_top_sva.sv */
`timescale 1ns/1ps
`default_nettype none

module soc_top_sva (
	input  wire               clock,
	input  wire               rst_n_i,
	input  soc_pkg::bus_req_t mem_req_i,
	input  wire               mem_req_valid_i,
	input  wire               mem_req_ready_i,
	input  soc_pkg::bus_rsp_t ifu_rsp_i,
	input  wire               ifu_rsp_valid_i,
	input  wire               ifu_rsp_ready_i,
	input  wire               ifu_req_ready_i,
	input  soc_pkg::bus_rsp_t lsu_rsp_i,
	input  wire               lsu_rsp_valid_i,
	input  wire               lsu_rsp_ready_i,
	input  wire               lsu_req_ready_i
);

	int fail_count = 0;

	// stalled memory request keeps its payload
	a_mem_req_stable: assert property (@(posedge clock) disable iff (!rst_n_i)
		mem_req_valid_i && !mem_req_ready_i |=> mem_req_valid_i && $stable(mem_req_i))
		else begin
			$error("memory request changed while stalled");
			fail_count++;
		end

	a_ifu_rsp_stable: assert property (@(posedge clock) disable iff (!rst_n_i)
		ifu_rsp_valid_i && !ifu_rsp_ready_i |=> ifu_rsp_valid_i && $stable(ifu_rsp_i))
		else begin
			$error("ifu response changed while stalled");
			fail_count++;
		end

	a_lsu_rsp_stable: assert property (@(posedge clock) disable iff (!rst_n_i)
		lsu_rsp_valid_i && !lsu_rsp_ready_i |=> lsu_rsp_valid_i && $stable(lsu_rsp_i))
		else begin
			$error("lsu response changed while stalled");
			fail_count++;
		end

	// an idle slot has nothing to answer
	a_ifu_idle: assert property (@(posedge clock) disable iff (!rst_n_i)
		ifu_req_ready_i |-> !ifu_rsp_valid_i)
		else begin
			$error("ifu response valid while slot idle");
			fail_count++;
		end

	a_lsu_idle: assert property (@(posedge clock) disable iff (!rst_n_i)
		lsu_req_ready_i |-> !lsu_rsp_valid_i)
		else begin
			$error("lsu response valid while slot idle");
			fail_count++;
		end

endmodule

bind soc_top soc_top_sva soc_top_sva_i (
	.clock           (clock),
	.rst_n_i         (rst_n_i),
	.mem_req_i       (mem_req_o),
	.mem_req_valid_i (mem_req_valid_o),
	.mem_req_ready_i (mem_req_ready_i),
	.ifu_rsp_i       (ifu_rsp_o),
	.ifu_rsp_valid_i (ifu_rsp_valid_o),
	.ifu_rsp_ready_i (ifu_rsp_ready_i),
	.ifu_req_ready_i (ifu_req_ready_o),
	.lsu_rsp_i       (lsu_rsp_o),
	.lsu_rsp_valid_i (lsu_rsp_valid_o),
	.lsu_rsp_ready_i (lsu_rsp_ready_i),
	.lsu_req_ready_i (lsu_req_ready_o)
);

`default_nettype wire

/* bench/tb_soc_top.sv */
`timescale 1ns/1ps
`default_nettype none

`include "soc_config.svh"

module tb_soc_top;

	localparam int COLS      = 9;
	localparam int MAX_LINES = 64;

	logic                    clock;
	logic                    rst_n;
	soc_pkg::bus_req_t [1:0] port_req;
	logic [1:0]              port_valid;
	wire [1:0]               port_ready;
	wire soc_pkg::bus_rsp_t [1:0] port_rsp;
	wire [1:0]               port_rsp_valid;
	logic [1:0]              port_rsp_ready;
	wire soc_pkg::bus_req_t  mem_req;
	wire                     mem_req_valid;
	logic                    mem_req_ready;
	soc_pkg::bus_rsp_t       mem_rsp;
	logic                    mem_rsp_valid;
	wire                     mem_rsp_ready;

	logic [31:0] td [0:COLS*MAX_LINES-1];
	logic [31:0] mem [0:255];
	logic [31:0] mem_log [$];
	logic [31:0] exp_log [$];
	int          errors;
	int          cycles;
	int          limit;
	int          last_grant;
	logic [31:0] last_rdata;

	soc_top soc_top_i (
		.clock           (clock),
		.rst_n_i         (rst_n),
		.ifu_req_i       (port_req[0]),
		.ifu_req_valid_i (port_valid[0]),
		.ifu_req_ready_o (port_ready[0]),
		.ifu_rsp_o       (port_rsp[0]),
		.ifu_rsp_valid_o (port_rsp_valid[0]),
		.ifu_rsp_ready_i (port_rsp_ready[0]),
		.lsu_req_i       (port_req[1]),
		.lsu_req_valid_i (port_valid[1]),
		.lsu_req_ready_o (port_ready[1]),
		.lsu_rsp_o       (port_rsp[1]),
		.lsu_rsp_valid_o (port_rsp_valid[1]),
		.lsu_rsp_ready_i (port_rsp_ready[1]),
		.mem_req_o       (mem_req),
		.mem_req_valid_o (mem_req_valid),
		.mem_req_ready_i (mem_req_ready),
		.mem_rsp_i       (mem_rsp),
		.mem_rsp_valid_i (mem_rsp_valid),
		.mem_rsp_ready_o (mem_rsp_ready)
	);

	initial clock = 1'b0;
	always #4 clock = ~clock;

	always @(posedge clock) begin
		cycles = cycles + 1;
		if (limit > 0 && cycles >= limit) begin
			$display("timeout: run did not finish within %0d cycles", limit);
			$display("errors: %0d", errors);
			$display("Some tests failed");
			$finish;
		end
	end

	task automatic check(input string name, input logic [31:0] exp, input logic [31:0] act);
		if (act !== exp) begin
			$display("error: %s expected %h actual %h", name, exp, act);
			errors++;
		end
	endtask

	function automatic bit in_timer(input logic [31:0] addr);
		return (addr - `SOC_CLINT_BASE) < `SOC_CLINT_SIZE;
	endfunction

	// only memory-side addresses should reach the memory port
	task automatic expect_mem(input int n);
		if (!in_timer(td[n*COLS+3]))
			exp_log.push_back(td[n*COLS+3]);
	endtask

	task automatic check_mem_order(input int n);
		while (exp_log.size() > 0) begin
			if (mem_log.size() == 0) begin
				$display("memory request for %h never arrived (line %0d)", exp_log[0], n);
				errors++;
				exp_log.delete(0);
			end else begin
				check($sformatf("line %0d memory order", n), exp_log.pop_front(),
					mem_log.pop_front());
			end
		end
		if (mem_log.size() > 0) begin
			$display("unexpected memory request at %h after line %0d", mem_log[0], n);
			errors++;
			mem_log.delete();
		end
	endtask

	// issue one line on its port, then take and check the response
	task automatic run_line(input int n);
		int                base;
		int                p;
		int                chk;
		bit                taken;
		string             name;
		soc_pkg::bus_req_t req;
		soc_pkg::bus_rsp_t rsp;
		base = n * COLS;
		p = td[base+1];
		chk = td[base+8];
		name = $sformatf("line %0d", n);
		req.addr = td[base+3];
		req.wdata = td[base+4];
		req.wstrb = td[base+5][3:0];
		req.size = 3'd2;
		req.op = soc_pkg::bus_op_e'(td[base+2][0]);
		@(negedge clock);
		port_req[p] = req;
		port_valid[p] = 1'b1;
		#1;
		while (!port_ready[p]) begin
			@(negedge clock);
			#1;
		end
		@(negedge clock);
		port_valid[p] = 1'b0;
		taken = 1'b0;
		while (!taken) begin
			port_rsp_ready[p] = ($urandom % 4) != 0;
			#1;
			if (port_rsp_valid[p] && port_rsp_ready[p]) begin
				rsp = port_rsp[p];
				taken = 1'b1;
			end
			@(negedge clock);
		end
		port_rsp_ready[p] = 1'b0;
		check({name, " resp"}, td[base+7], 32'(rsp.resp));
		if (chk == 0)
			check({name, " data"}, td[base+6], rsp.rdata);
		else if (chk == 2)
			check({name, " rising"}, 32'd1, 32'(rsp.rdata > last_rdata));
		last_rdata = rsp.rdata;
	endtask

	// word memory with random request stalls and response delays
	initial begin : memory_model
		soc_pkg::bus_req_t req;
		int                idx;
		mem_req_ready = 1'b0;
		mem_rsp_valid = 1'b0;
		mem_rsp = '0;
		forever begin
			@(negedge clock);
			mem_rsp_valid = 1'b0;
			mem_req_ready = ($urandom % 3) != 0;
			#1;
			if (mem_req_valid && mem_req_ready) begin
				req = mem_req;
				idx = req.addr[9:2];
				mem_log.push_back(req.addr);
				// every request is a single word beat
				check("memory request size", 32'd2, 32'(req.size));
				@(negedge clock);
				mem_req_ready = 1'b0;
				repeat ($urandom % 4) @(negedge clock);
				mem_rsp.resp = soc_pkg::RESP_OKAY;
				mem_rsp.rdata = '0;
				if (req.op == soc_pkg::OP_WRITE) begin
					for (int b = 0; b < 4; b++) begin
						if (req.wstrb[b])
							mem[idx][8*b +: 8] = req.wdata[8*b +: 8];
					end
				end else begin
					mem_rsp.rdata = mem[idx];
				end
				mem_rsp_valid = 1'b1;
				#1;
				while (!mem_rsp_ready) begin
					@(negedge clock);
					#1;
				end
			end
		end
	end

	initial begin
		int nlines;
		int n;
		int kind;
		int first;
		int second;
		int sva_errors;
		void'($urandom(32'h0035de96));
		rst_n = 1'b0;
		port_req = '0;
		port_valid = '0;
		port_rsp_ready = '0;
		errors = 0;
		cycles = 0;
		limit = 0;
		last_rdata = '0;
		// reset leaves the last slot as previous grant
		last_grant = `SOC_NUM_REQ - 1;
		$readmemh("bench/soc_testdata.txt", td);
		nlines = 0;
		while (nlines < MAX_LINES && td[nlines*COLS] !== 32'hf)
			nlines++;
		limit = nlines * 64;
		repeat (5) @(negedge clock);
		rst_n = 1'b1;
		for (n = 0; n < nlines; n++) begin
			kind = td[n*COLS];
			if (kind == 0) begin
				mem[td[n*COLS+3][9:2]] = td[n*COLS+4];
			end else if (kind == 1) begin
				expect_mem(n);
				last_grant = td[n*COLS+1];
				run_line(n);
				check_mem_order(n);
			end else if (kind == 2) begin
				// round robin picks the port after the last one granted
				if (td[n*COLS+1] != last_grant) begin
					first = n;
					second = n + 1;
				end else begin
					first = n + 1;
					second = n;
				end
				expect_mem(first);
				expect_mem(second);
				last_grant = td[second*COLS+1];
				fork
					run_line(n);
					run_line(n + 1);
				join
				check_mem_order(n);
				n++;
			end
		end
		sva_errors = soc_top_i.soc_top_sva_i.fail_count;
		$display("errors: %0d checks, %0d assertions", errors, sva_errors);
		if (errors == 0 && sva_errors == 0) begin
			$display("All tests passed");
		end else begin
			$display("Some tests failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

/* hw/addr_router.sv */
`timescale 1ns/1ps
`default_nettype none

`include "soc_config.svh"

module addr_router (
	input  wire                                     clock,
	input  wire                                     rst_n_i,
	input  soc_pkg::bus_req_t                       req_i,
	input  wire                                     req_valid_i,
	output logic                                    req_ready_o,
	output soc_pkg::bus_rsp_t                       rsp_o,
	output logic                                    rsp_valid_o,
	// memory bus
	output soc_pkg::bus_req_t                       mem_req_o,
	output logic                                    mem_req_valid_o,
	input  wire                                     mem_req_ready_i,
	input  soc_pkg::bus_rsp_t                       mem_rsp_i,
	input  wire                                     mem_rsp_valid_i,
	output logic                                    mem_rsp_ready_o,
	// core-local timer
	output logic                                    tmr_rd_o,
	output logic [$clog2(`SOC_CLINT_SIZE)-1:0]      tmr_ofs_o,
	input  soc_pkg::bus_rsp_t                       tmr_rsp_i,
	input  wire                                     tmr_rsp_valid_i
);

	localparam int OFS_W = $clog2(`SOC_CLINT_SIZE);
	localparam logic [`SOC_ADDR_W-1:0] TMR_BASE = `SOC_CLINT_BASE;
	localparam logic [OFS_W-1:0] LO_OFS = OFS_W'(`SOC_MTIME_LO_OFS);
	localparam logic [OFS_W-1:0] HI_OFS = OFS_W'(`SOC_MTIME_HI_OFS);

	logic             is_tmr;
	logic             mapped;
	logic             imm_rsp;
	logic [OFS_W-1:0] ofs;
	logic             busy_q;
	logic             tgt_tmr_q;
	logic             out_done;

	assign ofs     = req_i.addr[OFS_W-1:0];
	assign is_tmr  = (req_i.addr[`SOC_ADDR_W-1:OFS_W] == TMR_BASE[`SOC_ADDR_W-1:OFS_W]);
	assign mapped  = (ofs == LO_OFS) || (ofs == HI_OFS);
	// timer writes and holes are refused on the spot
	assign imm_rsp = req_valid_i && is_tmr && (req_i.op == soc_pkg::OP_WRITE || !mapped);

	assign mem_req_o       = req_i;
	assign mem_req_valid_o = req_valid_i && !is_tmr;
	assign req_ready_o     = is_tmr ? 1'b1 : mem_req_ready_i;

	assign tmr_rd_o  = req_valid_i && is_tmr && !imm_rsp;
	assign tmr_ofs_o = ofs;

	// forward only the target that owns the transaction
	assign mem_rsp_ready_o = busy_q && !tgt_tmr_q;
	assign out_done = busy_q && (tgt_tmr_q ? tmr_rsp_valid_i : mem_rsp_valid_i);
	assign rsp_valid_o = out_done || imm_rsp;

	always_comb begin
		rsp_o = mem_rsp_i;
		if (imm_rsp) begin
			rsp_o.rdata = '0;
			rsp_o.resp  = (req_i.op == soc_pkg::OP_WRITE) ?
				soc_pkg::RESP_SLVERR : soc_pkg::RESP_DECERR;
		end else if (tgt_tmr_q) begin
			rsp_o = tmr_rsp_i;
		end
	end

	always_ff @(posedge clock or negedge rst_n_i) begin
		if (!rst_n_i) begin
			busy_q    <= 1'b0;
			tgt_tmr_q <= 1'b0;
		end else if (mem_req_valid_o && mem_req_ready_i) begin
			busy_q    <= 1'b1;
			tgt_tmr_q <= 1'b0;
		end else if (tmr_rd_o) begin
			busy_q    <= 1'b1;
			tgt_tmr_q <= 1'b1;
		end else if (out_done) begin
			busy_q <= 1'b0;
		end
	end

endmodule

`default_nettype wire

/* hw/bus_arbiter.sv */
`timescale 1ns/1ps
`default_nettype none

`include "soc_config.svh"

module bus_arbiter (
	input  wire                                    clock,
	input  wire                                    rst_n_i,
	input  wire [`SOC_NUM_REQ-1:0]                 pend_i,
	input  soc_pkg::bus_req_t [`SOC_NUM_REQ-1:0]   pend_req_i,
	output logic [`SOC_NUM_REQ-1:0]                done_o,
	output soc_pkg::bus_rsp_t                      done_rsp_o,
	// downstream towards the router
	output soc_pkg::bus_req_t                      down_req_o,
	output logic                                   down_valid_o,
	input  wire                                    down_ready_i,
	input  soc_pkg::bus_rsp_t                      down_rsp_i,
	input  wire                                    down_rsp_valid_i
);

	localparam int NUM   = `SOC_NUM_REQ;
	localparam int IDX_W = (NUM > 1) ? $clog2(NUM) : 1;

	soc_pkg::arb_state_e state_q;
	logic [IDX_W-1:0]    grant_q;
	logic [IDX_W-1:0]    next_idx;
	soc_pkg::bus_req_t   req_q;
	logic                finish;
	int                  cand;

	// first pending slot after the last one granted
	always_comb begin
		next_idx = grant_q;
		cand     = 0;
		for (int k = NUM; k >= 1; k--) begin
			cand = (int'(grant_q) + k) % NUM;
			if (pend_i[cand])
				next_idx = IDX_W'(cand);
		end
	end

	// a response may come back in the issue cycle (timer errors)
	assign finish = down_rsp_valid_i &&
		((state_q == soc_pkg::ARB_WAIT) ||
		 (state_q == soc_pkg::ARB_ISSUE && down_ready_i));

	assign down_req_o   = req_q;
	assign down_valid_o = (state_q == soc_pkg::ARB_ISSUE);
	assign done_rsp_o   = down_rsp_i;

	always_comb begin
		done_o = '0;
		if (finish)
			done_o[grant_q] = 1'b1;
	end

	always_ff @(posedge clock or negedge rst_n_i) begin
		if (!rst_n_i) begin
			state_q <= soc_pkg::ARB_IDLE;
			// last slot so that port 0 wins first
			grant_q <= IDX_W'(NUM - 1);
		end else begin
			case (state_q)
				soc_pkg::ARB_IDLE: begin
					if (|pend_i) begin
						grant_q <= next_idx;
						state_q <= soc_pkg::ARB_ISSUE;
					end
				end
				soc_pkg::ARB_ISSUE: begin
					if (finish)
						state_q <= soc_pkg::ARB_IDLE;
					else if (down_ready_i)
						state_q <= soc_pkg::ARB_WAIT;
				end
				soc_pkg::ARB_WAIT: begin
					if (finish)
						state_q <= soc_pkg::ARB_IDLE;
				end
				default: state_q <= soc_pkg::ARB_IDLE;
			endcase
		end
	end

	always_ff @(posedge clock) begin
		if (state_q == soc_pkg::ARB_IDLE && |pend_i)
			req_q <= pend_req_i[next_idx];
	end

endmodule

`default_nettype wire

/* hw/clint_timer.sv */
`timescale 1ns/1ps
`default_nettype none

`include "soc_config.svh"

module clint_timer (
	input  wire                                 clock,
	input  wire                                 rst_n_i,
	input  wire                                 rd_i,
	input  wire [$clog2(`SOC_CLINT_SIZE)-1:0]   ofs_i,
	output soc_pkg::bus_rsp_t                   rsp_o,
	output logic                                rsp_valid_o
);

	localparam int OFS_W = $clog2(`SOC_CLINT_SIZE);
	localparam logic [OFS_W-1:0] LO_OFS = OFS_W'(`SOC_MTIME_LO_OFS);
	localparam logic [OFS_W-1:0] HI_OFS = OFS_W'(`SOC_MTIME_HI_OFS);

	logic [63:0] mtime_q;

	// free running, one tick per clock
	always_ff @(posedge clock or negedge rst_n_i) begin
		if (!rst_n_i) begin
			mtime_q     <= '0;
			rsp_valid_o <= 1'b0;
		end else begin
			mtime_q     <= mtime_q + 64'd1;
			rsp_valid_o <= rd_i;
		end
	end

	// answer lands one cycle after the read
	always_ff @(posedge clock) begin
		if (rd_i) begin
			case (ofs_i)
				LO_OFS: rsp_o <= '{rdata: mtime_q[31:0], resp: soc_pkg::RESP_OKAY};
				HI_OFS: rsp_o <= '{rdata: mtime_q[63:32], resp: soc_pkg::RESP_OKAY};
				default: rsp_o <= '{rdata: '0, resp: soc_pkg::RESP_DECERR};
			endcase
		end
	end

endmodule

`default_nettype wire

/* hw/req_slot.sv */
`timescale 1ns/1ps
`default_nettype none

`include "soc_config.svh"

module req_slot (
	input  wire               clock,
	input  wire               rst_n_i,
	// requester side
	input  soc_pkg::bus_req_t req_i,
	input  wire               req_valid_i,
	output logic              req_ready_o,
	output soc_pkg::bus_rsp_t rsp_o,
	output logic              rsp_valid_o,
	input  wire               rsp_ready_i,
	// arbiter side
	output logic              pend_o,
	output soc_pkg::bus_req_t pend_req_o,
	input  wire               done_i,
	input  soc_pkg::bus_rsp_t done_rsp_i
);

	logic              pend_q;
	logic              full_q;
	soc_pkg::bus_req_t req_q;
	soc_pkg::bus_rsp_t rsp_q;

	// empty only when neither waiting on the bus nor holding a response
	assign req_ready_o = !pend_q && !full_q;
	assign pend_o      = pend_q;
	assign pend_req_o  = req_q;
	assign rsp_o       = rsp_q;
	assign rsp_valid_o = full_q;

	always_ff @(posedge clock or negedge rst_n_i) begin
		if (!rst_n_i) begin
			pend_q <= 1'b0;
			full_q <= 1'b0;
		end else begin
			if (req_valid_i && req_ready_o) begin
				pend_q <= 1'b1;
			end else if (done_i) begin
				pend_q <= 1'b0;
				full_q <= 1'b1;
			end else if (full_q && rsp_ready_i) begin
				full_q <= 1'b0;
			end
		end
	end

	// payload capture
	always_ff @(posedge clock) begin
		if (req_valid_i && req_ready_o)
			req_q <= req_i;
		if (done_i)
			rsp_q <= done_rsp_i;
	end

endmodule

`default_nettype wire

/* hw/soc_config.svh */
`ifndef SOC_CONFIG_SVH
`define SOC_CONFIG_SVH

// bus widths
`define SOC_ADDR_W 32
`define SOC_DATA_W 32

// ifu and lsu
`define SOC_NUM_REQ 2

// core-local timer window, 64 KiB
`define SOC_CLINT_BASE 32'h0200_0000
`define SOC_CLINT_SIZE 32'h0001_0000

// mtime halves inside the window
`define SOC_MTIME_LO_OFS 32'hbff8
`define SOC_MTIME_HI_OFS 32'hbffc

`endif

/* hw/soc_pkg.sv */
`default_nettype none

`include "soc_config.svh"

package soc_pkg;

	typedef enum logic {
		OP_READ  = 1'b0,
		OP_WRITE = 1'b1
	} bus_op_e;

	// same codes as AXI rresp/bresp
	typedef enum logic [1:0] {
		RESP_OKAY   = 2'b00,
		RESP_SLVERR = 2'b10,
		RESP_DECERR = 2'b11
	} bus_resp_e;

	typedef enum logic [1:0] {
		ARB_IDLE  = 2'd0,
		ARB_ISSUE = 2'd1,
		ARB_WAIT  = 2'd2
	} arb_state_e;

	// single beat request, 72 bits
	typedef struct packed {
		logic [`SOC_ADDR_W-1:0]   addr;
		logic [`SOC_DATA_W-1:0]   wdata;
		logic [`SOC_DATA_W/8-1:0] wstrb;
		logic [2:0]               size;
		bus_op_e                  op;
	} bus_req_t;

	// read data plus status, 34 bits
	typedef struct packed {
		logic [`SOC_DATA_W-1:0] rdata;
		bus_resp_e              resp;
	} bus_rsp_t;

endpackage

`default_nettype wire

/* hw/soc_top.sv */
`timescale 1ns/1ps
`default_nettype none

`include "soc_config.svh"

module soc_top (
	input  wire               clock,
	input  wire               rst_n_i,
	// instruction fetch, slot 0
	input  soc_pkg::bus_req_t ifu_req_i,
	input  wire               ifu_req_valid_i,
	output logic              ifu_req_ready_o,
	output soc_pkg::bus_rsp_t ifu_rsp_o,
	output logic              ifu_rsp_valid_o,
	input  wire               ifu_rsp_ready_i,
	// load/store, slot 1
	input  soc_pkg::bus_req_t lsu_req_i,
	input  wire               lsu_req_valid_i,
	output logic              lsu_req_ready_o,
	output soc_pkg::bus_rsp_t lsu_rsp_o,
	output logic              lsu_rsp_valid_o,
	input  wire               lsu_rsp_ready_i,
	// external memory bus
	output soc_pkg::bus_req_t mem_req_o,
	output logic              mem_req_valid_o,
	input  wire               mem_req_ready_i,
	input  soc_pkg::bus_rsp_t mem_rsp_i,
	input  wire               mem_rsp_valid_i,
	output logic              mem_rsp_ready_o
);

	localparam int NUM   = `SOC_NUM_REQ;
	localparam int OFS_W = $clog2(`SOC_CLINT_SIZE);

	soc_pkg::bus_req_t [NUM-1:0] up_req;
	soc_pkg::bus_rsp_t [NUM-1:0] up_rsp;
	logic [NUM-1:0]              up_req_valid;
	logic [NUM-1:0]              up_req_ready;
	logic [NUM-1:0]              up_rsp_valid;
	logic [NUM-1:0]              up_rsp_ready;

	logic [NUM-1:0]              pend;
	soc_pkg::bus_req_t [NUM-1:0] pend_req;
	logic [NUM-1:0]              done;
	soc_pkg::bus_rsp_t           done_rsp;

	soc_pkg::bus_req_t           down_req;
	logic                        down_valid;
	logic                        down_ready;
	soc_pkg::bus_rsp_t           down_rsp;
	logic                        down_rsp_valid;

	logic                        tmr_rd;
	logic [OFS_W-1:0]            tmr_ofs;
	soc_pkg::bus_rsp_t           tmr_rsp;
	logic                        tmr_rsp_valid;

	// ifu on slot 0, lsu on slot 1
	assign up_req[0]       = ifu_req_i;
	assign up_req_valid[0] = ifu_req_valid_i;
	assign up_rsp_ready[0] = ifu_rsp_ready_i;
	assign ifu_req_ready_o = up_req_ready[0];
	assign ifu_rsp_o       = up_rsp[0];
	assign ifu_rsp_valid_o = up_rsp_valid[0];

	assign up_req[1]       = lsu_req_i;
	assign up_req_valid[1] = lsu_req_valid_i;
	assign up_rsp_ready[1] = lsu_rsp_ready_i;
	assign lsu_req_ready_o = up_req_ready[1];
	assign lsu_rsp_o       = up_rsp[1];
	assign lsu_rsp_valid_o = up_rsp_valid[1];

	for (genvar g = 0; g < NUM; g++) begin : g_slot
		req_slot u_slot (
			.clock       (clock),
			.rst_n_i     (rst_n_i),
			.req_i       (up_req[g]),
			.req_valid_i (up_req_valid[g]),
			.req_ready_o (up_req_ready[g]),
			.rsp_o       (up_rsp[g]),
			.rsp_valid_o (up_rsp_valid[g]),
			.rsp_ready_i (up_rsp_ready[g]),
			.pend_o      (pend[g]),
			.pend_req_o  (pend_req[g]),
			.done_i      (done[g]),
			.done_rsp_i  (done_rsp)
		);
	end

	bus_arbiter u_arbiter (
		.clock            (clock),
		.rst_n_i          (rst_n_i),
		.pend_i           (pend),
		.pend_req_i       (pend_req),
		.done_o           (done),
		.done_rsp_o       (done_rsp),
		.down_req_o       (down_req),
		.down_valid_o     (down_valid),
		.down_ready_i     (down_ready),
		.down_rsp_i       (down_rsp),
		.down_rsp_valid_i (down_rsp_valid)
	);

	addr_router u_router (
		.clock           (clock),
		.rst_n_i         (rst_n_i),
		.req_i           (down_req),
		.req_valid_i     (down_valid),
		.req_ready_o     (down_ready),
		.rsp_o           (down_rsp),
		.rsp_valid_o     (down_rsp_valid),
		.mem_req_o       (mem_req_o),
		.mem_req_valid_o (mem_req_valid_o),
		.mem_req_ready_i (mem_req_ready_i),
		.mem_rsp_i       (mem_rsp_i),
		.mem_rsp_valid_i (mem_rsp_valid_i),
		.mem_rsp_ready_o (mem_rsp_ready_o),
		.tmr_rd_o        (tmr_rd),
		.tmr_ofs_o       (tmr_ofs),
		.tmr_rsp_i       (tmr_rsp),
		.tmr_rsp_valid_i (tmr_rsp_valid)
	);

	clint_timer u_clint (
		.clock       (clock),
		.rst_n_i     (rst_n_i),
		.rd_i        (tmr_rd),
		.ofs_i       (tmr_ofs),
		.rsp_o       (tmr_rsp),
		.rsp_valid_o (tmr_rsp_valid)
	);

endmodule

`default_nettype wire

/* sources.f */
+incdir+hw
hw/soc_pkg.sv
hw/req_slot.sv
hw/bus_arbiter.sv
hw/addr_router.sv
hw/clint_timer.sv
hw/soc_top.sv
bench/soc_top_sva.sv
bench/tb_soc_top.sv
